/* branch_unit.sv */
`include "cpu_params.svh"

module branch_unit (
    input  logic            valid_i,
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   inst_i,
    input  id_pkg::branch_e branch_kind_i,
    input  id_pkg::word_t   reg1_i,
    input  id_pkg::word_t   reg2_i,
    output logic            branch_flag_o,
    output id_pkg::word_t   branch_target_address_o,
    output id_pkg::word_t   link_addr_o
);
    import id_pkg::*;

    logic [5:0] op;
    logic [5:0] func;
    word_t      pc_plus_4;
    word_t      pc_plus_8;
    word_t      jidx_target;
    word_t      br_offset;
    word_t      target;
    logic       taken;
    logic       is_link;

    assign op   = inst_i[`OP_MSB:`OP_LSB];
    assign func = inst_i[`FUNC_MSB:`FUNC_LSB];

    assign pc_plus_4   = pc_i + word_t'(4);
    assign pc_plus_8   = pc_i + word_t'(8);
    assign jidx_target = {pc_plus_4[`REG_W-1 -: 4], inst_i[`JIDX_W-1:0], 2'b00};
    assign br_offset   = {{(`REG_W-`IMM_W-2){inst_i[`IMM_W-1]}}, inst_i[`IMM_W-1:0], 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = pc_plus_4 + br_offset;  // Conditional branch target
        case (branch_kind_i)
            BR_JIDX: begin
                taken  = 1'b1;
                target = jidx_target;
            end
            BR_JREG: begin
                taken  = 1'b1;
                target = reg1_i;
            end
            BR_BEQ:  taken = (reg1_i == reg2_i);
            BR_BNE:  taken = (reg1_i != reg2_i);
            BR_BGTZ: taken = !reg1_i[`REG_W-1] && (reg1_i != '0);
            BR_BLEZ: taken = reg1_i[`REG_W-1] || (reg1_i == '0);
            default: taken = 1'b0;
        endcase
    end

    assign branch_flag_o           = valid_i && taken;
    assign branch_target_address_o = branch_flag_o ? target : '0;

    // Return address skips the delay slot
    assign is_link     = (op == OP_JAL) || ((op == OP_SPECIAL) && (func == FUNC_JALR));
    assign link_addr_o = is_link ? pc_plus_8 : '0;

endmodule

/* compile.f */
+incdir+.
id_pkg.sv
inst_decoder.sv
operand_fwd.sv
branch_unit.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define REG_W      32
`define REG_ADDR_W 5

// JAL writes its return address here
`define LINK_REG   31

// Instruction word fields
`define OP_MSB     31
`define OP_LSB     26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11
`define SA_MSB     10
`define SA_LSB     6
`define FUNC_MSB   5
`define FUNC_LSB   0
`define IMM_W      16  // I-type immediate, bits 15..0
`define JIDX_W     26  // J-type index, bits 25..0

`endif

/* id_ex_reg.sv */
module id_ex_reg (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              valid_i,
    input  id_pkg::alu_op_e   aluop_i,
    input  id_pkg::alu_sel_e  alusel_i,
    input  id_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  id_pkg::word_t     reg1_i,
    input  id_pkg::word_t     reg2_i,
    input  id_pkg::word_t     link_addr_i,
    input  logic              inst_valid_i,
    output logic              valid_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output id_pkg::word_t     link_addr_o,
    output logic              inst_invalid_o
);
    import id_pkg::*;

    always_ff @(posedge clk) begin
        if (rst_i || !valid_i) begin  // Bubble loads the same state as reset
            valid_o        <= 1'b0;
            aluop_o        <= ALU_NOP;
            alusel_o       <= SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= '0;
            wreg_o         <= 1'b0;
            link_addr_o    <= '0;
            inst_invalid_o <= 1'b0;
        end else begin
            valid_o        <= 1'b1;
            aluop_o        <= aluop_i;
            alusel_o       <= alusel_i;
            reg1_o         <= reg1_i;
            reg2_o         <= reg2_i;
            wd_o           <= wd_i;
            wreg_o         <= wreg_i;
            link_addr_o    <= link_addr_i;
            inst_invalid_o <= !inst_valid_i;
        end
    end

endmodule

/* id_pkg.sv */
`include "cpu_params.svh"

package id_pkg;

    typedef logic [`REG_W-1:0]      word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation codes handed to execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_AND   = 8'b0010_0100, ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110, ALU_NOR   = 8'b0010_0111,
        ALU_ANDI  = 8'b0101_1001, ALU_ORI   = 8'b0101_1010,
        ALU_XORI  = 8'b0101_1011,
        ALU_SLL   = 8'b0111_1100, ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000, ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010, ALU_SUBU  = 8'b0010_0011,
        ALU_SLT   = 8'b0010_1010, ALU_SLTU  = 8'b0010_1011,
        ALU_ADDI  = 8'b0101_0101, ALU_ADDIU = 8'b0101_0110,
        ALU_SLTI  = 8'b0101_0111, ALU_SLTIU = 8'b0101_1000,
        ALU_J     = 8'b0100_1111, ALU_JAL   = 8'b0101_0000,
        ALU_JR    = 8'b0000_1000, ALU_JALR  = 8'b0000_1001,
        ALU_BEQ   = 8'b0101_0001, ALU_BNE   = 8'b0101_0010,
        ALU_BLEZ  = 8'b0101_0011, ALU_BGTZ  = 8'b0101_0100
    } alu_op_e;

    // Result class picked in execute
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100,
        SEL_JUMP  = 3'b110
    } alu_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_JIDX, BR_JREG, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ
    } branch_e;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL function field
    localparam logic [5:0] FUNC_SLL   = 6'b000000;
    localparam logic [5:0] FUNC_SRL   = 6'b000010;
    localparam logic [5:0] FUNC_SRA   = 6'b000011;
    localparam logic [5:0] FUNC_SLLV  = 6'b000100;
    localparam logic [5:0] FUNC_SRLV  = 6'b000110;
    localparam logic [5:0] FUNC_SRAV  = 6'b000111;
    localparam logic [5:0] FUNC_JR    = 6'b001000;
    localparam logic [5:0] FUNC_JALR  = 6'b001001;
    localparam logic [5:0] FUNC_ADD   = 6'b100000;
    localparam logic [5:0] FUNC_ADDU  = 6'b100001;
    localparam logic [5:0] FUNC_SUB   = 6'b100010;
    localparam logic [5:0] FUNC_SUBU  = 6'b100011;
    localparam logic [5:0] FUNC_AND   = 6'b100100;
    localparam logic [5:0] FUNC_OR    = 6'b100101;
    localparam logic [5:0] FUNC_XOR   = 6'b100110;
    localparam logic [5:0] FUNC_NOR   = 6'b100111;
    localparam logic [5:0] FUNC_SLT   = 6'b101010;
    localparam logic [5:0] FUNC_SLTU  = 6'b101011;

endpackage

/* id_stage.sv */
module id_stage (
    input  logic              clk,
    input  logic              rst_i,
    // From fetch
    input  logic              valid_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     inst_i,
    // Register file
    input  id_pkg::word_t     reg1_data_i,
    input  id_pkg::word_t     reg2_data_i,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    // Forwarding from EX and MEM
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    // Back to fetch, same cycle
    output logic              branch_flag_o,
    output id_pkg::word_t     branch_target_address_o,
    // To execute
    output logic              valid_o,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::word_t     reg1_o,
    output id_pkg::word_t     reg2_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output id_pkg::word_t     link_addr_o,
    output logic              inst_invalid_o
);
    import id_pkg::*;

    alu_op_e   dec_aluop;
    alu_sel_e  dec_alusel;
    reg_addr_t dec_wd;
    logic      dec_wreg;
    word_t     dec_imm;
    logic      dec_valid;
    branch_e   dec_branch;
    word_t     fwd_reg1;
    word_t     fwd_reg2;
    word_t     link_addr;

    inst_decoder u_decoder (
        .inst_i(inst_i), .aluop_o(dec_aluop), .alusel_o(dec_alusel),
        .wd_o(dec_wd), .wreg_o(dec_wreg),
        .reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
        .reg1_addr_o(reg1_addr_o), .reg2_addr_o(reg2_addr_o),
        .imm_o(dec_imm), .inst_valid_o(dec_valid), .branch_kind_o(dec_branch)
    );

    operand_fwd u_fwd1 (
        .read_i(reg1_read_o), .addr_i(reg1_addr_o), .imm_i(dec_imm),
        .rf_data_i(reg1_data_i),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .operand_o(fwd_reg1)
    );

    operand_fwd u_fwd2 (
        .read_i(reg2_read_o), .addr_i(reg2_addr_o), .imm_i(dec_imm),
        .rf_data_i(reg2_data_i),
        .ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
        .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
        .operand_o(fwd_reg2)
    );

    branch_unit u_branch (
        .valid_i(valid_i), .pc_i(pc_i), .inst_i(inst_i), .branch_kind_i(dec_branch),
        .reg1_i(fwd_reg1), .reg2_i(fwd_reg2),
        .branch_flag_o(branch_flag_o), .branch_target_address_o(branch_target_address_o),
        .link_addr_o(link_addr)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .rst_i(rst_i), .valid_i(valid_i),
        .aluop_i(dec_aluop), .alusel_i(dec_alusel), .wd_i(dec_wd), .wreg_i(dec_wreg),
        .reg1_i(fwd_reg1), .reg2_i(fwd_reg2), .link_addr_i(link_addr),
        .inst_valid_i(dec_valid),
        .valid_o(valid_o), .aluop_o(aluop_o), .alusel_o(alusel_o),
        .reg1_o(reg1_o), .reg2_o(reg2_o), .wd_o(wd_o), .wreg_o(wreg_o),
        .link_addr_o(link_addr_o), .inst_invalid_o(inst_invalid_o)
    );

endmodule

/* inst_decoder.sv */
`include "cpu_params.svh"

module inst_decoder (
    input  id_pkg::word_t     inst_i,
    output id_pkg::alu_op_e   aluop_o,
    output id_pkg::alu_sel_e  alusel_o,
    output id_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output logic              reg1_read_o,
    output logic              reg2_read_o,
    output id_pkg::reg_addr_t reg1_addr_o,
    output id_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::word_t     imm_o,
    output logic              inst_valid_o,
    output id_pkg::branch_e   branch_kind_o
);
    import id_pkg::*;

    logic [5:0]          op;
    logic [5:0]          func;
    reg_addr_t           rs;
    reg_addr_t           rt;
    reg_addr_t           rd;
    logic [4:0]          sa;
    logic [`IMM_W-1:0]   imm16;
    logic                fixed_shift;
    logic                jump_reg;

    assign op    = inst_i[`OP_MSB:`OP_LSB];
    assign func  = inst_i[`FUNC_MSB:`FUNC_LSB];
    assign rs    = inst_i[`RS_MSB:`RS_LSB];
    assign rt    = inst_i[`RT_MSB:`RT_LSB];
    assign rd    = inst_i[`RD_MSB:`RD_LSB];
    assign sa    = inst_i[`SA_MSB:`SA_LSB];
    assign imm16 = inst_i[`IMM_W-1:0];

    assign fixed_shift = (func == FUNC_SLL) || (func == FUNC_SRL) || (func == FUNC_SRA);
    assign jump_reg    = (func == FUNC_JR) || (func == FUNC_JALR);

    assign reg1_addr_o  = rs;
    assign reg2_addr_o  = rt;
    assign inst_valid_o = (aluop_o != ALU_NOP);  // Every kept instruction has a real code

    // Operation code
    always_comb begin
        aluop_o = ALU_NOP;
        case (op)
            OP_SPECIAL: begin
                case (func)
                    FUNC_SLL:  aluop_o = (rs == '0) ? ALU_SLL : ALU_NOP;
                    FUNC_SRL:  aluop_o = (rs == '0) ? ALU_SRL : ALU_NOP;
                    FUNC_SRA:  aluop_o = (rs == '0) ? ALU_SRA : ALU_NOP;
                    FUNC_SLLV: aluop_o = ALU_SLL;
                    FUNC_SRLV: aluop_o = ALU_SRL;
                    FUNC_SRAV: aluop_o = ALU_SRA;
                    FUNC_JR:   aluop_o = ALU_JR;
                    FUNC_JALR: aluop_o = ALU_JALR;
                    FUNC_ADD:  aluop_o = ALU_ADD;
                    FUNC_ADDU: aluop_o = ALU_ADDU;
                    FUNC_SUB:  aluop_o = ALU_SUB;
                    FUNC_SUBU: aluop_o = ALU_SUBU;
                    FUNC_AND:  aluop_o = ALU_AND;
                    FUNC_OR:   aluop_o = ALU_OR;
                    FUNC_XOR:  aluop_o = ALU_XOR;
                    FUNC_NOR:  aluop_o = ALU_NOR;
                    FUNC_SLT:  aluop_o = ALU_SLT;
                    FUNC_SLTU: aluop_o = ALU_SLTU;
                    default:   aluop_o = ALU_NOP;
                endcase
            end
            OP_ORI:   aluop_o = ALU_ORI;
            OP_ANDI:  aluop_o = ALU_ANDI;
            OP_XORI:  aluop_o = ALU_XORI;
            OP_LUI:   aluop_o = ALU_OR;    // Upper immediate ORed with itself
            OP_ADDI:  aluop_o = ALU_ADDI;
            OP_ADDIU: aluop_o = ALU_ADDIU;
            OP_SLTI:  aluop_o = ALU_SLTI;
            OP_SLTIU: aluop_o = ALU_SLTIU;
            OP_J:     aluop_o = ALU_J;
            OP_JAL:   aluop_o = ALU_JAL;
            OP_BEQ:   aluop_o = ALU_BEQ;
            OP_BNE:   aluop_o = ALU_BNE;
            OP_BGTZ:  aluop_o = ALU_BGTZ;
            OP_BLEZ:  aluop_o = ALU_BLEZ;
            default:  aluop_o = ALU_NOP;
        endcase
    end

    // Result class follows from the operation
    always_comb begin
        case (aluop_o)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ANDI, ALU_ORI, ALU_XORI:
                alusel_o = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:
                alusel_o = SEL_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
            ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU:
                alusel_o = SEL_ARITH;
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ:
                alusel_o = SEL_JUMP;
            default:
                alusel_o = SEL_NOP;
        endcase
    end

    // Operand reads, destination and immediate
    always_comb begin
        wd_o          = rd;
        wreg_o        = 1'b0;
        reg1_read_o   = 1'b0;
        reg2_read_o   = 1'b0;
        imm_o         = '0;
        branch_kind_o = BR_NONE;
        case (op)
            OP_SPECIAL: begin
                reg1_read_o = !fixed_shift;  // Fixed shifts take sa as operand 1
                reg2_read_o = !jump_reg;
                wreg_o      = (func != FUNC_JR);
                if (fixed_shift) begin
                    imm_o = word_t'(sa);
                end
                if (jump_reg) begin
                    branch_kind_o = BR_JREG;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_ADDIU: begin
                reg1_read_o = 1'b1;
                wreg_o      = 1'b1;
                wd_o        = rt;
                imm_o       = word_t'(imm16);
            end
            OP_ADDI, OP_SLTI, OP_SLTIU: begin
                reg1_read_o = 1'b1;
                wreg_o      = 1'b1;
                wd_o        = rt;
                imm_o       = {{(`REG_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            OP_LUI: begin
                wreg_o = 1'b1;
                wd_o   = rt;
                imm_o  = {imm16, {(`REG_W-`IMM_W){1'b0}}};
            end
            OP_J: branch_kind_o = BR_JIDX;
            OP_JAL: begin
                wreg_o        = 1'b1;
                wd_o          = reg_addr_t'(`LINK_REG);
                branch_kind_o = BR_JIDX;
            end
            OP_BEQ, OP_BNE: begin
                reg1_read_o   = 1'b1;
                reg2_read_o   = 1'b1;
                branch_kind_o = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_BGTZ, OP_BLEZ: begin
                reg1_read_o   = 1'b1;
                branch_kind_o = (op == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
            end
            default: ;
        endcase
        if (!inst_valid_o) begin  // Unknown word does nothing
            wreg_o        = 1'b0;
            reg1_read_o   = 1'b0;
            reg2_read_o   = 1'b0;
            imm_o         = '0;
            branch_kind_o = BR_NONE;
        end
    end

endmodule

/* operand_fwd.sv */
module operand_fwd (
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::word_t     rf_data_i,
    input  logic              ex_wreg_i,
    input  id_pkg::reg_addr_t ex_wd_i,
    input  id_pkg::word_t     ex_wdata_i,
    input  logic              mem_wreg_i,
    input  id_pkg::reg_addr_t mem_wd_i,
    input  id_pkg::word_t     mem_wdata_i,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // Register 0 is forwarded like any other
    assign ex_hit  = read_i && ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = read_i && mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (ex_hit) begin
            operand_o = ex_wdata_i;    // Youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else if (read_i) begin
            operand_o = rf_data_i;
        end else begin
            operand_o = imm_i;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
rm -f build.log sim.log
verilator --binary -f compile.f --top-module tb_id_stage -o sim_id_stage > build.log 2>&1 \
    && ./obj_dir/sim_id_stage > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    localparam word_t PC0     = 32'h0000_1000;
    localparam word_t PCJ     = 32'h3000_0100;
    localparam int    RST_IDX = 63;

    typedef struct {
        string     name;
        logic      valid;
        word_t     pc;
        word_t     inst;
        logic      ex_we;
        reg_addr_t ex_wd;
        logic      mem_we;
        reg_addr_t mem_wd;
        int        force1;   // 0 random, 1 positive, 2 negative, 3 zero
        alu_op_e   op;
        alu_sel_e  sel;
        reg_addr_t wd;
        logic      wreg;
        logic      rd1;
        logic      rd2;
        word_t     imm;
        logic      br;
        word_t     tgt;
        logic      tgt_op1;  // Target is operand 1
        word_t     link;
        logic      inval;
    } entry_t;

    logic clk, rst_i, valid_i;
    word_t pc_i, inst_i, reg1_data_i, reg2_data_i, ex_wdata_i, mem_wdata_i;
    logic ex_wreg_i, mem_wreg_i;
    reg_addr_t ex_wd_i, mem_wd_i;
    logic reg1_read_o, reg2_read_o, branch_flag_o, valid_o, wreg_o, inst_invalid_o;
    reg_addr_t reg1_addr_o, reg2_addr_o, wd_o;
    word_t branch_target_address_o, reg1_o, reg2_o, link_addr_o;
    alu_op_e aluop_o;
    alu_sel_e alusel_o;

    entry_t tbl[$];
    word_t  exp_r1[64];
    word_t  exp_r2[64];
    word_t  exp_tgt[64];
    int     fails[64];
    int     n_pass = 0;
    int     n_fail = 0;
    int     cycles = 0;
    int     limit = 0;
    word_t  rng = 32'd80;

    id_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

    function automatic word_t xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic word_t rtype(int rs, int rt, int rd, int sa, logic [5:0] fn);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic word_t itype(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t jtype(logic [5:0] op, logic [25:0] idx);
        return {op, idx};
    endfunction

    // EX beats MEM beats register file, immediate when not read
    function automatic word_t pick_operand(logic rd, reg_addr_t a, word_t imm, word_t rf,
                                           entry_t e, word_t exd, word_t memd);
        if (!rd) return imm;
        if (e.ex_we && e.ex_wd == a) return exd;
        if (e.mem_we && e.mem_wd == a) return memd;
        return rf;
    endfunction

    function automatic string test_name(int idx);
        return (idx == RST_IDX) ? "reset" : tbl[idx].name;
    endfunction

    task automatic add(string name, int valid, word_t pc, word_t inst, int ex_we, int ex_wd,
                       int mem_we, int mem_wd, int force1, alu_op_e op, alu_sel_e sel,
                       int wd, int wreg, int rd1, int rd2, word_t imm, int br, word_t tgt,
                       int tgt_op1, word_t link, int inval);
        entry_t e;
        e.name = name;
        e.valid = valid[0];
        e.pc = pc;
        e.inst = inst;
        e.ex_we = ex_we[0];
        e.ex_wd = reg_addr_t'(ex_wd);
        e.mem_we = mem_we[0];
        e.mem_wd = reg_addr_t'(mem_wd);
        e.force1 = force1;
        e.op = op;
        e.sel = sel;
        e.wd = reg_addr_t'(wd);
        e.wreg = wreg[0];
        e.rd1 = rd1[0];
        e.rd2 = rd2[0];
        e.imm = imm;
        e.br = br[0];
        e.tgt = tgt;
        e.tgt_op1 = tgt_op1[0];
        e.link = link;
        e.inval = inval[0];
        tbl.push_back(e);
    endtask

    task automatic check_word(int idx, string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", test_name(idx), what, exp, act);
            fails[idx]++;
        end
    endtask

    task automatic check_addr(int idx, string what, reg_addr_t exp, reg_addr_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %0d actual %0d", test_name(idx), what, exp, act);
            fails[idx]++;
        end
    endtask

    task automatic check_op(int idx, alu_op_e exp, alu_op_e act);
        if (exp !== act) begin
            $display("[FAIL] %s aluop expected %h actual %h", test_name(idx), exp, act);
            fails[idx]++;
        end
    endtask

    task automatic check_sel(int idx, alu_sel_e exp, alu_sel_e act);
        if (exp !== act) begin
            $display("[FAIL] %s alusel expected %h actual %h", test_name(idx), exp, act);
            fails[idx]++;
        end
    endtask

    task automatic check_bit(int idx, string what, logic exp, logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %b actual %b", test_name(idx), what, exp, act);
            fails[idx]++;
        end
    endtask

    task automatic check_cleared(int idx);
        check_bit(idx, "valid_o", 1'b0, valid_o);
        check_op(idx, ALU_NOP, aluop_o);
        check_sel(idx, SEL_NOP, alusel_o);
        check_word(idx, "reg1_o", '0, reg1_o);
        check_word(idx, "reg2_o", '0, reg2_o);
        check_addr(idx, "wd_o", '0, wd_o);
        check_bit(idx, "wreg_o", 1'b0, wreg_o);
        check_word(idx, "link_addr_o", '0, link_addr_o);
        check_bit(idx, "inst_invalid_o", 1'b0, inst_invalid_o);
    endtask

    task automatic drive(int idx);
        entry_t e;
        word_t  rf1, rf2, exd, memd;
        e = tbl[idx];
        rf1 = xorshift();
        rf2 = xorshift();
        exd = xorshift();
        memd = xorshift();
        case (e.force1)
            1: rf1 = {1'b0, rf1[30:1], 1'b1};
            2: rf1 = {1'b1, rf1[30:0]};
            3: rf1 = '0;
            default: ;
        endcase
        exp_r1[idx] = pick_operand(e.rd1, e.inst[25:21], e.imm, rf1, e, exd, memd);
        exp_r2[idx] = pick_operand(e.rd2, e.inst[20:16], e.imm, rf2, e, exd, memd);
        exp_tgt[idx] = e.tgt_op1 ? exp_r1[idx] : e.tgt;
        valid_i <= e.valid;
        pc_i <= e.pc;
        inst_i <= e.inst;
        reg1_data_i <= rf1;
        reg2_data_i <= rf2;
        ex_wreg_i <= e.ex_we;
        ex_wd_i <= e.ex_wd;
        ex_wdata_i <= exd;
        mem_wreg_i <= e.mem_we;
        mem_wd_i <= e.mem_wd;
        mem_wdata_i <= memd;
    endtask

    task automatic check_comb(int idx);
        entry_t e;
        e = tbl[idx];
        check_bit(idx, "reg1_read_o", e.rd1, reg1_read_o);
        check_bit(idx, "reg2_read_o", e.rd2, reg2_read_o);
        if (e.rd1) check_addr(idx, "reg1_addr_o", e.inst[25:21], reg1_addr_o);
        if (e.rd2) check_addr(idx, "reg2_addr_o", e.inst[20:16], reg2_addr_o);
        check_bit(idx, "branch_flag_o", e.br && e.valid, branch_flag_o);
        check_word(idx, "branch_target", (e.br && e.valid) ? exp_tgt[idx] : '0,
                   branch_target_address_o);
    endtask

    task automatic check_reg(int idx);
        entry_t e;
        e = tbl[idx];
        if (!e.valid) begin
            check_cleared(idx);
        end else begin
            check_bit(idx, "valid_o", 1'b1, valid_o);
            check_op(idx, e.op, aluop_o);
            check_sel(idx, e.sel, alusel_o);
            check_word(idx, "reg1_o", exp_r1[idx], reg1_o);
            check_word(idx, "reg2_o", exp_r2[idx], reg2_o);
            check_bit(idx, "wreg_o", e.wreg, wreg_o);
            if (e.wreg) check_addr(idx, "wd_o", e.wd, wd_o);
            check_word(idx, "link_addr_o", e.link, link_addr_o);
            check_bit(idx, "inst_invalid_o", e.inval, inst_invalid_o);
        end
    endtask

    task automatic report(int idx);
        if (fails[idx] == 0) begin
            $display("test %-20s ok", test_name(idx));
            n_pass++;
        end else begin
            $display("test %-20s %0d mismatches", test_name(idx), fails[idx]);
            n_fail++;
        end
    endtask

    task automatic build_table();
        add("or", 1, PC0, rtype(1, 2, 3, 0, FUNC_OR), 0, 0, 0, 0, 0,
            ALU_OR, SEL_LOGIC, 3, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("sllv", 1, PC0, rtype(4, 5, 6, 0, FUNC_SLLV), 0, 0, 0, 0, 0,
            ALU_SLL, SEL_SHIFT, 6, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("sub", 1, PC0, rtype(7, 8, 9, 0, FUNC_SUB), 0, 0, 0, 0, 0,
            ALU_SUB, SEL_ARITH, 9, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("ori", 1, PC0, itype(OP_ORI, 1, 10, 16'h8001), 0, 0, 0, 0, 0,
            ALU_ORI, SEL_LOGIC, 10, 1, 1, 0, 32'h0000_8001, 0, 0, 0, 0, 0);
        add("addi", 1, PC0, itype(OP_ADDI, 2, 11, 16'hfff0), 0, 0, 0, 0, 0,
            ALU_ADDI, SEL_ARITH, 11, 1, 1, 0, 32'hffff_fff0, 0, 0, 0, 0, 0);
        add("lui", 1, PC0, itype(OP_LUI, 0, 12, 16'h1234), 0, 0, 0, 0, 0,
            ALU_OR, SEL_LOGIC, 12, 1, 0, 0, 32'h1234_0000, 0, 0, 0, 0, 0);
        add("sll", 1, PC0, rtype(0, 13, 14, 5, FUNC_SLL), 0, 0, 0, 0, 0,
            ALU_SLL, SEL_SHIFT, 14, 1, 0, 1, 5, 0, 0, 0, 0, 0);
        add("fwd_ex_over_mem", 1, PC0, rtype(1, 2, 3, 0, FUNC_OR), 1, 1, 1, 1, 0,
            ALU_OR, SEL_LOGIC, 3, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("fwd_mem_op2", 1, PC0, rtype(1, 2, 3, 0, FUNC_OR), 1, 5, 1, 2, 0,
            ALU_OR, SEL_LOGIC, 3, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("fwd_ex_op2", 1, PC0, rtype(1, 2, 3, 0, FUNC_OR), 1, 2, 1, 2, 0,
            ALU_OR, SEL_LOGIC, 3, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("fwd_miss", 1, PC0, rtype(1, 2, 3, 0, FUNC_OR), 1, 6, 1, 7, 0,
            ALU_OR, SEL_LOGIC, 3, 1, 1, 1, 0, 0, 0, 0, 0, 0);
        add("j", 1, PCJ, jtype(OP_J, 26'h12_3456), 0, 0, 0, 0, 0,
            ALU_J, SEL_JUMP, 0, 0, 0, 0, 0, 1, 32'h3048_d158, 0, 0, 0);
        add("jal", 1, PCJ, jtype(OP_JAL, 26'h12_3456), 0, 0, 0, 0, 0,
            ALU_JAL, SEL_JUMP, 31, 1, 0, 0, 0, 1, 32'h3048_d158, 0, 32'h3000_0108, 0);
        add("jr", 1, PC0, rtype(9, 0, 0, 0, FUNC_JR), 0, 0, 0, 0, 0,
            ALU_JR, SEL_JUMP, 0, 0, 1, 0, 0, 1, 0, 1, 0, 0);
        add("jalr", 1, PC0, rtype(9, 0, 17, 0, FUNC_JALR), 0, 0, 0, 0, 0,
            ALU_JALR, SEL_JUMP, 17, 1, 1, 0, 0, 1, 0, 1, 32'h0000_1008, 0);
        add("beq_taken_fwd", 1, PC0, itype(OP_BEQ, 3, 3, 16'h0010), 1, 3, 0, 0, 0,
            ALU_BEQ, SEL_JUMP, 0, 0, 1, 1, 0, 1, 32'h0000_1044, 0, 0, 0);
        add("beq_not_taken", 1, PC0, itype(OP_BEQ, 1, 2, 16'hfffc), 0, 0, 0, 0, 0,
            ALU_BEQ, SEL_JUMP, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
        add("bne_taken", 1, PC0, itype(OP_BNE, 1, 2, 16'hfffc), 0, 0, 0, 0, 0,
            ALU_BNE, SEL_JUMP, 0, 0, 1, 1, 0, 1, 32'h0000_0ff4, 0, 0, 0);
        add("bne_not_taken_fwd", 1, PC0, itype(OP_BNE, 4, 4, 16'h0010), 0, 0, 1, 4, 0,
            ALU_BNE, SEL_JUMP, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
        add("bgtz_taken", 1, PC0, itype(OP_BGTZ, 5, 0, 16'h0008), 0, 0, 0, 0, 1,
            ALU_BGTZ, SEL_JUMP, 0, 0, 1, 0, 0, 1, 32'h0000_1024, 0, 0, 0);
        add("bgtz_not_taken", 1, PC0, itype(OP_BGTZ, 5, 0, 16'h0008), 0, 0, 0, 0, 3,
            ALU_BGTZ, SEL_JUMP, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
        add("blez_taken", 1, PC0, itype(OP_BLEZ, 5, 0, 16'h0002), 0, 0, 0, 0, 2,
            ALU_BLEZ, SEL_JUMP, 0, 0, 1, 0, 0, 1, 32'h0000_100c, 0, 0, 0);
        add("blez_not_taken", 1, PC0, itype(OP_BLEZ, 5, 0, 16'h0002), 0, 0, 0, 0, 1,
            ALU_BLEZ, SEL_JUMP, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
        // SPECIAL word with an unused function field
        add("invalid", 1, PC0, rtype(1, 2, 3, 0, 6'b111111), 0, 0, 0, 0, 0,
            ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
        add("bubble", 0, PCJ, jtype(OP_JAL, 26'h40), 0, 0, 0, 0, 0,
            ALU_JAL, SEL_JUMP, 31, 1, 0, 0, 0, 0, 0, 0, 0, 0);  // No flag without valid
    endtask

    initial begin
        rst_i = 1'b1;
        valid_i = 1'b1;  // A live instruction during reset must not reach ID/EX
        pc_i = PC0;
        inst_i = rtype(1, 2, 3, 0, FUNC_OR);
        reg1_data_i = 32'h1234_5678;
        reg2_data_i = 32'h8765_4321;
        ex_wreg_i = 1'b0;
        ex_wd_i = '0;
        ex_wdata_i = '0;
        mem_wreg_i = 1'b0;
        mem_wd_i = '0;
        mem_wdata_i = '0;
        build_table();
        limit = tbl.size() + 4 + 20;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        valid_i <= 1'b0;
        @(negedge clk);
        check_cleared(RST_IDX);
        report(RST_IDX);
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            drive(i);
            @(negedge clk);
            check_comb(i);
            if (i > 0) begin
                check_reg(i - 1);  // Previous entry now sits in ID/EX
                report(i - 1);
            end
        end
        @(posedge clk);
        valid_i <= 1'b0;
        @(negedge clk);
        check_reg(tbl.size() - 1);
        report(tbl.size() - 1);
        $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
